/* logic/router_regs_settings.svh */
// Router register block build constants
// Port counts, word widths and the values reported in the parameter registers
`ifndef ROUTER_REGS_SETTINGS_SVH
`define ROUTER_REGS_SETTINGS_SVH

//////////////////////////////////////////////////
// Port counts

`define RR_NUM_ING_PORTS   4      // Ingress ports
`define RR_NUM_EGR_PORTS   4      // Egress ports

//////////////////////////////////////////////////
// Word widths

`define RR_CNT_WIDTH       32     // One statistics counter
`define RR_DATA_WIDTH      32     // Register bus data
`define RR_ADDR_WIDTH      8      // Register bus word address

//////////////////////////////////////////////////
// Reported router parameters

`define RR_MTU_BYTES       1500   // PARAMS1, low 16 bits
`define RR_BUS_DATA_BYTES  64     // PARAMS0, datapath width in bytes

//////////////////////////////////////////////////
// Counters per port

`define RR_NUM_EXT_CNTS    3      // Packet, byte and error counts from the port
`define RR_NUM_ING_EVENTS  2      // Async FIFO overflow, buffer overflow
`define RR_NUM_EGR_EVENTS  1      // Buffer-full drop

`endif

/* logic/router_regs_pkg.sv */
// Router register block shared types
// Bus and counter words, register map and counter selector encodings
`default_nettype none

`include "router_regs_settings.svh"

package router_regs_pkg;

    //////////////////////////////////////////////////
    // Word types

    typedef logic [`RR_DATA_WIDTH-1:0] reg_word_t;   // One bus data word
    typedef logic [`RR_CNT_WIDTH-1:0]  cnt_word_t;   // One statistics counter

    //////////////////////////////////////////////////
    // Register map

    // Word addresses, one register per word
    typedef enum logic [`RR_ADDR_WIDTH-1:0] {
        ADDR_PARAMS0 = 0,       // Bus bytes, egress and ingress port counts
        ADDR_PARAMS1,           // MTU in bytes
        ADDR_ING_ENABLE_CON,    // Ingress port enables, reset to ones
        ADDR_EGR_ENABLE_CON,    // Egress port enables, reset to ones
        ADDR_ING_ENABLE_STAT,   // Ingress connected status
        ADDR_EGR_ENABLE_STAT,   // Egress connected status
        ADDR_ING_SAMPLE_CON,    // Rising bit samples that ingress port
        ADDR_ING_READ_SEL,      // Port in 15..8, counter in 7..0
        ADDR_ING_READ_DATA,     // Selected ingress snapshot word
        ADDR_EGR_SAMPLE_CON,    // Rising bit samples that egress port
        ADDR_EGR_READ_SEL,      // Port in 15..8, counter in 7..0
        ADDR_EGR_READ_DATA,     // Selected egress snapshot word
        ADDR_REG_COUNT          // First undefined address
    } reg_addr_e;

    //////////////////////////////////////////////////
    // Counter selectors

    // Low three follow the external count order on every port
    // Local drop events start right after them
    typedef enum logic [7:0] {
        CNT_PKT  = 0,   // Packets seen, errored ones included
        CNT_BYTE = 1,   // Bytes seen, errored packets included
        CNT_ERR  = 2,   // Packets flagged errored by the MAC
        CNT_EVT0 = 3,   // Ingress async FIFO overflow, egress buffer-full drop
        CNT_EVT1 = 4    // Ingress buffer overflow
    } cnt_sel_e;

endpackage

`default_nettype wire

/* logic/port_stats_if.sv */
// Link between the register responder and one statistics bank
// Sample levels and readback selects go out, the selected snapshot word comes back
`default_nettype none

`include "router_regs_settings.svh"

interface port_stats_if
    import router_regs_pkg::*;
#(
    parameter int NUM_PORTS  = 4,
    parameter int NUM_EVENTS = 1
);

    localparam int NUM_CNTS = `RR_NUM_EXT_CNTS + NUM_EVENTS;   // Words per port snapshot

    logic [NUM_PORTS-1:0] sample_con;      // Sample bit per port, level
    logic [7:0]           read_port_sel;   // Port of the readback word
    cnt_sel_e             read_cnt_sel;    // Counter of the readback word
    cnt_word_t            read_data;       // Selected snapshot word
    logic                 sel_valid;       // Both selects within this bank

    // Out of range on either select reads back zero
    assign sel_valid = (int'(read_port_sel) < NUM_PORTS) &&
                       (int'(read_cnt_sel) < NUM_CNTS);

    modport regs (
        output sample_con,
        output read_port_sel,
        output read_cnt_sel,
        input  read_data
    );

    modport bank (
        input  sample_con,
        input  read_port_sel,
        input  read_cnt_sel,
        input  sel_valid,
        output read_data
    );

endinterface

`default_nettype wire

/* logic/port_stats_bank.sv */
// Per-port statistics bank
// Counts local drop events, captures snapshots on sample rise, returns selected word
`default_nettype none

`include "router_regs_settings.svh"

module port_stats_bank
    import router_regs_pkg::*;
#(
    parameter int NUM_PORTS  = 4,
    parameter int NUM_EVENTS = 1
) (
    input  logic                                          core_clk_ifc,
    input  logic                                          interconnect_sreset_core,
    input  cnt_word_t [NUM_PORTS-1:0][`RR_NUM_EXT_CNTS-1:0] ext_cnts,   // Pkt, byte, err
    input  logic [NUM_PORTS-1:0][NUM_EVENTS-1:0]          events,     // Drop strobes
    output logic [NUM_PORTS-1:0]                          cnts_clear, // One pulse per sample
    port_stats_if.bank                                    stats
);

    //////////////////////////////////////////////////
    // Sizes

    localparam int NUM_CNTS   = `RR_NUM_EXT_CNTS + NUM_EVENTS;
    localparam int PORT_IDX_W = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;
    localparam int CNT_IDX_W  = $clog2(NUM_CNTS);   // At least 4 words, so 2 bits or more

    //////////////////////////////////////////////////
    // Declarations

    logic [NUM_PORTS-1:0] sample_d1;     // Sample bits, first stage
    logic [NUM_PORTS-1:0] sample_d2;     // Previous value for edge detect
    logic [NUM_PORTS-1:0] sample_rise;

    logic [NUM_PORTS-1:0][NUM_EVENTS-1:0] events_d;
    logic [NUM_PORTS-1:0][NUM_EVENTS-1:0] event_rise;

    cnt_word_t [NUM_PORTS-1:0][NUM_EVENTS-1:0] event_cnt;   // Running local drop counts
    cnt_word_t [NUM_PORTS-1:0][NUM_CNTS-1:0]   snapshot;    // Captured words per port

    logic [PORT_IDX_W-1:0] port_idx;
    logic [CNT_IDX_W-1:0]  cnt_idx;

    //////////////////////////////////////////////////
    // Edge detection

    assign sample_rise = sample_d1 & ~sample_d2;   // 0 to 1 of a sample bit
    assign event_rise  = events & ~events_d;       // One count per event edge

    //////////////////////////////////////////////////
    // Counting and capture

    always_ff @(posedge core_clk_ifc) begin
        if (interconnect_sreset_core) begin
            sample_d1  <= '0;
            sample_d2  <= '0;
            events_d   <= '0;
            event_cnt  <= '0;
            snapshot   <= '0;
            cnts_clear <= '0;
        end else begin
            sample_d1  <= stats.sample_con;
            sample_d2  <= sample_d1;
            events_d   <= events;
            cnts_clear <= sample_rise;   // High the cycle after capture

            for (int p = 0; p < NUM_PORTS; p++) begin
                if (sample_rise[p]) begin
                    // External counts keep cnt_sel_e order
                    for (int c = 0; c < `RR_NUM_EXT_CNTS; c++) begin
                        snapshot[p][c] <= ext_cnts[p][c];
                    end
                    // Local counts follow, then restart from zero
                    for (int e = 0; e < NUM_EVENTS; e++) begin
                        snapshot[p][`RR_NUM_EXT_CNTS + e] <= event_cnt[p][e];
                        event_cnt[p][e]                  <= '0;
                    end
                end else begin
                    for (int e = 0; e < NUM_EVENTS; e++) begin
                        if (event_rise[p][e]) begin
                            event_cnt[p][e] <= event_cnt[p][e] + cnt_word_t'(1);   // Wraps
                        end
                    end
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Readback

    assign port_idx = stats.read_port_sel[PORT_IDX_W-1:0];
    assign cnt_idx  = stats.read_cnt_sel[CNT_IDX_W-1:0];

    // Pure function of selects and stored words
    assign stats.read_data = stats.sel_valid ? snapshot[port_idx][cnt_idx] : '0;

    //////////////////////////////////////////////////
    // Checks

    // Sample stages keep a rise to a single cycle
    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_clear_chk
        assert property (@(posedge core_clk_ifc) disable iff (interconnect_sreset_core)
            cnts_clear[p] |=> !cnts_clear[p])
            else $error("cnts_clear held two cycles on port %0d", p);
    end

endmodule

`default_nettype wire

/* logic/reg_bus_responder.sv */
// Register bus responder for the router control block
// Holds the control registers, decodes strobes and answers one cycle later
`default_nettype none

`include "router_regs_settings.svh"

module reg_bus_responder
    import router_regs_pkg::*;
(
    input  logic                          core_clk_ifc,
    input  logic                          interconnect_sreset_core,
    input  logic                          rd_en,
    input  logic                          wr_en,
    input  logic [`RR_ADDR_WIDTH-1:0]     addr,
    input  reg_word_t                     wr_data,
    output reg_word_t                     rd_data,    // Valid with rd_valid
    output logic                          rd_valid,
    output logic                          wr_ack,
    output logic                          resp_err,   // Undefined address
    input  logic [`RR_NUM_ING_PORTS-1:0]  ing_ports_connected,
    input  logic [`RR_NUM_EGR_PORTS-1:0]  egr_ports_connected,
    output logic [`RR_NUM_ING_PORTS-1:0]  ing_ports_enable,
    output logic [`RR_NUM_EGR_PORTS-1:0]  egr_ports_enable,
    port_stats_if.regs                    ing_stats,
    port_stats_if.regs                    egr_stats
);

    localparam int NI = `RR_NUM_ING_PORTS;
    localparam int NE = `RR_NUM_EGR_PORTS;

    // Fixed parameter words
    localparam reg_word_t PARAMS0_WORD = {8'd0, 8'(`RR_BUS_DATA_BYTES), 8'(NE), 8'(NI)};
    localparam reg_word_t PARAMS1_WORD = {16'd0, 16'(`RR_MTU_BYTES)};

    //////////////////////////////////////////////////
    // Register storage

    logic [NI-1:0] ing_enable_con;     // Port bits only, upper bits read zero
    logic [NE-1:0] egr_enable_con;
    logic [NI-1:0] ing_enable_stat;
    logic [NE-1:0] egr_enable_stat;
    logic [NI-1:0] ing_sample_con;
    logic [NE-1:0] egr_sample_con;
    logic [7:0]    ing_port_sel;
    logic [7:0]    egr_port_sel;
    cnt_sel_e      ing_cnt_sel;
    cnt_sel_e      egr_cnt_sel;

    logic          addr_undef;
    reg_word_t     rd_mux;

    assign addr_undef = (addr >= ADDR_REG_COUNT);

    always_ff @(posedge core_clk_ifc) begin
        if (interconnect_sreset_core) begin
            rd_valid         <= 1'b0;
            wr_ack           <= 1'b0;
            resp_err         <= 1'b0;
            ing_enable_con   <= '1;       // All ports on out of reset
            egr_enable_con   <= '1;
            ing_ports_enable <= '1;
            egr_ports_enable <= '1;
            ing_enable_stat  <= '0;
            egr_enable_stat  <= '0;
            ing_sample_con   <= '0;
            egr_sample_con   <= '0;
            ing_port_sel     <= '0;
            egr_port_sel     <= '0;
            ing_cnt_sel      <= CNT_PKT;
            egr_cnt_sel      <= CNT_PKT;
        end else begin
            rd_valid <= rd_en;                         // Fixed one-cycle response
            wr_ack   <= wr_en;
            resp_err <= (rd_en | wr_en) & addr_undef;

            ing_ports_enable <= ing_enable_con;        // Registered copies of CON
            egr_ports_enable <= egr_enable_con;
            ing_enable_stat  <= ing_ports_connected;
            egr_enable_stat  <= egr_ports_connected;

            // Read-only and undefined addresses fall through
            if (wr_en) begin
                case (addr)
                    ADDR_ING_ENABLE_CON: ing_enable_con <= wr_data[NI-1:0];
                    ADDR_EGR_ENABLE_CON: egr_enable_con <= wr_data[NE-1:0];
                    ADDR_ING_SAMPLE_CON: ing_sample_con <= wr_data[NI-1:0];
                    ADDR_EGR_SAMPLE_CON: egr_sample_con <= wr_data[NE-1:0];
                    ADDR_ING_READ_SEL: begin
                        ing_port_sel <= wr_data[15:8];
                        ing_cnt_sel  <= cnt_sel_e'(wr_data[7:0]);
                    end
                    ADDR_EGR_READ_SEL: begin
                        egr_port_sel <= wr_data[15:8];
                        egr_cnt_sel  <= cnt_sel_e'(wr_data[7:0]);
                    end
                    default: ;
                endcase
            end
        end
    end

    //////////////////////////////////////////////////
    // Read path

    always_comb begin
        rd_mux = '0;   // Undefined addresses read zero
        case (addr)
            ADDR_PARAMS0:         rd_mux = PARAMS0_WORD;
            ADDR_PARAMS1:         rd_mux = PARAMS1_WORD;
            ADDR_ING_ENABLE_CON:  rd_mux = reg_word_t'(ing_enable_con);
            ADDR_EGR_ENABLE_CON:  rd_mux = reg_word_t'(egr_enable_con);
            ADDR_ING_ENABLE_STAT: rd_mux = reg_word_t'(ing_enable_stat);
            ADDR_EGR_ENABLE_STAT: rd_mux = reg_word_t'(egr_enable_stat);
            ADDR_ING_SAMPLE_CON:  rd_mux = reg_word_t'(ing_sample_con);
            ADDR_ING_READ_SEL:    rd_mux = {16'd0, ing_port_sel, 8'(ing_cnt_sel)};
            ADDR_ING_READ_DATA:   rd_mux = reg_word_t'(ing_stats.read_data);
            ADDR_EGR_SAMPLE_CON:  rd_mux = reg_word_t'(egr_sample_con);
            ADDR_EGR_READ_SEL:    rd_mux = {16'd0, egr_port_sel, 8'(egr_cnt_sel)};
            ADDR_EGR_READ_DATA:   rd_mux = reg_word_t'(egr_stats.read_data);
            default:              rd_mux = '0;
        endcase
    end

    always_ff @(posedge core_clk_ifc) begin
        if (rd_en) begin
            rd_data <= rd_mux;
        end
    end

    // Levels to the statistics banks
    assign ing_stats.sample_con    = ing_sample_con;
    assign ing_stats.read_port_sel = ing_port_sel;
    assign ing_stats.read_cnt_sel  = ing_cnt_sel;
    assign egr_stats.sample_con    = egr_sample_con;
    assign egr_stats.read_port_sel = egr_port_sel;
    assign egr_stats.read_cnt_sel  = egr_cnt_sel;

    //////////////////////////////////////////////////
    // Checks

    assert property (@(posedge core_clk_ifc) disable iff (interconnect_sreset_core)
        !(rd_en && wr_en))
        else $error("Read and write strobes together");

    // Every read response traces back to a strobe
    assert property (@(posedge core_clk_ifc) disable iff (interconnect_sreset_core)
        rd_valid |-> $past(rd_en))
        else $error("rd_valid without a read strobe");

endmodule

`default_nettype wire

/* logic/router_regs_top.sv */
// Router control and statistics register block
// Register responder plus one statistics bank per direction
`default_nettype none

`include "router_regs_settings.svh"

module router_regs_top
    import router_regs_pkg::*;
(
    input  logic                                                   core_clk_ifc,
    input  logic                                                   interconnect_sreset_core,
    // Register bus
    input  logic                                                   rd_en,
    input  logic                                                   wr_en,
    input  logic [`RR_ADDR_WIDTH-1:0]                              addr,
    input  reg_word_t                                              wr_data,
    output reg_word_t                                              rd_data,
    output logic                                                   rd_valid,
    output logic                                                   wr_ack,
    output logic                                                   resp_err,
    // Ingress ports
    output logic [`RR_NUM_ING_PORTS-1:0]                           ing_ports_enable,
    input  logic [`RR_NUM_ING_PORTS-1:0]                           ing_ports_connected,
    input  cnt_word_t [`RR_NUM_ING_PORTS-1:0][`RR_NUM_EXT_CNTS-1:0] ing_ext_cnts,
    input  logic [`RR_NUM_ING_PORTS-1:0][`RR_NUM_ING_EVENTS-1:0]   ing_events,
    output logic [`RR_NUM_ING_PORTS-1:0]                           ing_cnts_clear,
    // Egress ports
    output logic [`RR_NUM_EGR_PORTS-1:0]                           egr_ports_enable,
    input  logic [`RR_NUM_EGR_PORTS-1:0]                           egr_ports_connected,
    input  cnt_word_t [`RR_NUM_EGR_PORTS-1:0][`RR_NUM_EXT_CNTS-1:0] egr_ext_cnts,
    input  logic [`RR_NUM_EGR_PORTS-1:0][`RR_NUM_EGR_EVENTS-1:0]   egr_events,
    output logic [`RR_NUM_EGR_PORTS-1:0]                           egr_cnts_clear
);

    // One link per direction
    port_stats_if #(.NUM_PORTS(`RR_NUM_ING_PORTS), .NUM_EVENTS(`RR_NUM_ING_EVENTS)) ing_stats_bus ();
    port_stats_if #(.NUM_PORTS(`RR_NUM_EGR_PORTS), .NUM_EVENTS(`RR_NUM_EGR_EVENTS)) egr_stats_bus ();

    reg_bus_responder u_regs (
        .core_clk_ifc, .interconnect_sreset_core,
        .rd_en, .wr_en, .addr, .wr_data, .rd_data, .rd_valid, .wr_ack, .resp_err,
        .ing_ports_connected, .egr_ports_connected, .ing_ports_enable, .egr_ports_enable,
        .ing_stats (ing_stats_bus.regs),
        .egr_stats (egr_stats_bus.regs)
    );

    port_stats_bank #(.NUM_PORTS(`RR_NUM_ING_PORTS), .NUM_EVENTS(`RR_NUM_ING_EVENTS)) u_ing_stats (
        .core_clk_ifc, .interconnect_sreset_core,
        .ext_cnts   (ing_ext_cnts),
        .events     (ing_events),      // Async FIFO overflow, buffer overflow
        .cnts_clear (ing_cnts_clear),
        .stats      (ing_stats_bus.bank)
    );

    port_stats_bank #(.NUM_PORTS(`RR_NUM_EGR_PORTS), .NUM_EVENTS(`RR_NUM_EGR_EVENTS)) u_egr_stats (
        .core_clk_ifc, .interconnect_sreset_core,
        .ext_cnts   (egr_ext_cnts),
        .events     (egr_events),      // Buffer-full drop
        .cnts_clear (egr_cnts_clear),
        .stats      (egr_stats_bus.bank)
    );

endmodule

`default_nettype wire

/* dv/router_regs_tb.sv */
// Router register block testbench
// Replays the vector file on the bus and port inputs and checks every response
`default_nettype none

`include "router_regs_settings.svh"

module router_regs_tb
    import router_regs_pkg::*;
();

    localparam int NI      = `RR_NUM_ING_PORTS;
    localparam int NE      = `RR_NUM_EGR_PORTS;
    localparam int TIMEOUT = 50;   // Cycles per wait

    logic                      core_clk_ifc = 1'b0;
    logic                      interconnect_sreset_core;
    logic                      rd_en;
    logic                      wr_en;
    logic [`RR_ADDR_WIDTH-1:0] addr;
    reg_word_t                 wr_data;
    reg_word_t                 rd_data;
    logic                      rd_valid;
    logic                      wr_ack;
    logic                      resp_err;

    logic [NI-1:0]                              ing_ports_enable;
    logic [NI-1:0]                              ing_ports_connected;
    cnt_word_t [NI-1:0][`RR_NUM_EXT_CNTS-1:0]   ing_ext_cnts;
    logic [NI-1:0][`RR_NUM_ING_EVENTS-1:0]      ing_events;
    logic [NI-1:0]                              ing_cnts_clear;
    logic [NE-1:0]                              egr_ports_enable;
    logic [NE-1:0]                              egr_ports_connected;
    cnt_word_t [NE-1:0][`RR_NUM_EXT_CNTS-1:0]   egr_ext_cnts;
    logic [NE-1:0][`RR_NUM_EGR_EVENTS-1:0]      egr_events;
    logic [NE-1:0]                              egr_cnts_clear;

    int errors   = 0;
    int timeouts = 0;

    always #10 core_clk_ifc = ~core_clk_ifc;   // Period 20

    router_regs_top dut (.*);

    //////////////////////////////////////////////////
    // Helpers

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected)
        else begin
            $display("[FAIL] %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
            errors++;
        end
    endtask

    // Falling edge sampling, outputs settled by then
    task automatic wait_response(input logic is_read, input string name);
        int n;
        n = 0;
        @(negedge core_clk_ifc);
        while (!(is_read ? rd_valid : wr_ack) && n < TIMEOUT) begin
            @(negedge core_clk_ifc);
            n++;
        end
        if (n >= TIMEOUT) begin
            $display("Timed out waiting for the bus response in %s", name);
            timeouts++;
        end else begin
            // Answer due in the cycle right after the strobe edge
            check_value({name, " response delay"}, 32'd0, 32'(n));
        end
    endtask

    // One-cycle strobe, returns in the response cycle
    task automatic bus_access(input logic is_read, input logic [7:0] a, input reg_word_t d,
                              input string name);
        @(posedge core_clk_ifc);
        rd_en   <= is_read;
        wr_en   <= !is_read;
        addr    <= a;
        wr_data <= d;
        @(posedge core_clk_ifc);
        rd_en <= 1'b0;
        wr_en <= 1'b0;
        wait_response(is_read, name);
    endtask

    function automatic logic clear_bit(input logic egr, input int port);
        return egr ? egr_cnts_clear[port] : ing_cnts_clear[port];
    endfunction

    // Rising edges two cycles apart
    task automatic pulse_event(input logic egr, input int port, input int ev, input int count);
        repeat (count) begin
            @(posedge core_clk_ifc);
            if (egr) begin
                egr_events[port][ev] <= 1'b1;
            end else begin
                ing_events[port][ev] <= 1'b1;
            end
            @(posedge core_clk_ifc);
            if (egr) begin
                egr_events[port][ev] <= 1'b0;
            end else begin
                ing_events[port][ev] <= 1'b0;
            end
        end
    endtask

    // Raise then drop the sample bit, one clear pulse expected
    task automatic sample_port(input logic egr, input int port, input string name);
        int         n;
        int         pulses;
        logic [7:0] con_addr;
        con_addr = egr ? ADDR_EGR_SAMPLE_CON : ADDR_ING_SAMPLE_CON;
        n        = 0;
        pulses   = 0;
        bus_access(1'b0, con_addr, 32'(1) << port, name);
        while (!clear_bit(egr, port) && n < TIMEOUT) begin
            @(negedge core_clk_ifc);
            n++;
        end
        if (n >= TIMEOUT) begin
            $display("Timed out waiting for the counter clear in %s", name);
            timeouts++;
        end
        repeat (4) begin   // A stretched clear shows up here
            if (clear_bit(egr, port)) begin
                pulses++;
            end
            @(negedge core_clk_ifc);
        end
        bus_access(1'b0, con_addr, '0, name);
        check_value({name, " clear pulses"}, 32'd1, 32'(pulses));
    endtask

    //////////////////////////////////////////////////
    // Vector replay

    initial begin
        int         fd;
        int         line_no;
        int         n;
        int         port;
        int         idx;
        int         cnt;
        string      line;
        string      op;
        string      side;
        string      name;
        logic [7:0] a;
        logic [31:0] v;
        logic       egr;

        void'($urandom(86460));
        interconnect_sreset_core <= 1'b1;
        rd_en               <= 1'b0;
        wr_en               <= 1'b0;
        addr                <= '0;
        wr_data             <= '0;
        ing_ports_connected <= '0;
        egr_ports_connected <= '0;
        ing_ext_cnts        <= '0;
        egr_ext_cnts        <= '0;
        ing_events          <= '0;
        egr_events          <= '0;
        repeat (3) @(posedge core_clk_ifc);
        interconnect_sreset_core <= 1'b0;

        fd = $fopen("dv/router_regs_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open the vector file");
            errors++;
        end else begin
            line_no = 0;
            while (!$feof(fd)) begin
                line = "";
                n    = $fgets(line, fd);
                line_no++;
                if (line.len() < 2 || line.getc(0) == "#") begin
                    continue;   // Blank or column notes
                end
                n    = $sscanf(line, "%s", op);
                name = $sformatf("line %0d op %s", line_no, op);
                case (op)
                    "W", "F": begin
                        n = $sscanf(line, "%s %h %h", op, a, v);
                        bus_access(1'b0, a, v, name);
                        check_value({name, " resp_err"}, (op == "F") ? 32'd1 : 32'd0,
                                    32'(resp_err));
                    end
                    "R": begin
                        n = $sscanf(line, "%s %h %h", op, a, v);
                        bus_access(1'b1, a, '0, name);
                        check_value(name, v, rd_data);
                        check_value({name, " resp_err"}, 32'd0, 32'(resp_err));
                    end
                    "E": begin
                        n = $sscanf(line, "%s %h", op, a);
                        bus_access(1'b1, a, '0, name);
                        check_value({name, " resp_err"}, 32'd1, 32'(resp_err));
                        check_value(name, 32'd0, rd_data);   // Error reads zero
                    end
                    "X": begin
                        n   = $sscanf(line, "%s %s %d %d %h", op, side, port, idx, v);
                        egr = (side == "egr");
                        @(posedge core_clk_ifc);
                        if (egr) begin
                            egr_ext_cnts[port][idx] <= v;
                        end else begin
                            ing_ext_cnts[port][idx] <= v;
                        end
                    end
                    "P": begin
                        n = $sscanf(line, "%s %s %d %d %d", op, side, port, idx, cnt);
                        pulse_event(side == "egr", port, idx, cnt);
                    end
                    "S": begin
                        n = $sscanf(line, "%s %s %d", op, side, port);
                        sample_port(side == "egr", port, name);
                    end
                    "C": begin
                        n = $sscanf(line, "%s %s %h", op, side, v);
                        @(posedge core_clk_ifc);
                        if (side == "egr") begin
                            egr_ports_connected <= v[NE-1:0];
                        end else begin
                            ing_ports_connected <= v[NI-1:0];
                        end
                    end
                    "O": begin
                        n = $sscanf(line, "%s %s %h", op, side, v);
                        repeat (2) @(posedge core_clk_ifc);   // CON to output latency
                        @(negedge core_clk_ifc);
                        check_value(name, v, (side == "egr") ? 32'(egr_ports_enable)
                                                             : 32'(ing_ports_enable));
                    end
                    default: begin
                        $display("Unknown opcode on vector line %0d", line_no);
                        errors++;
                    end
                endcase
                repeat ($urandom_range(3, 0)) @(posedge core_clk_ifc);   // Idle gap
            end
            $fclose(fd);
        end

        repeat (4) @(posedge core_clk_ifc);
        $display("Check errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* router_regs.f */
+incdir+logic
logic/router_regs_pkg.sv
logic/port_stats_if.sv
logic/port_stats_bank.sv
logic/reg_bus_responder.sv
logic/router_regs_top.sv
dv/router_regs_tb.sv

/* Makefile */
# Verilator flow for the router register block

TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := router_regs_tb
FILELIST := router_regs.f
BUILD    := obj_dir
LOG      := sim.log
FAIL_MSG := Something failed

.PHONY: all lint build sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

sim: build
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || (cat $(LOG); exit 1)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported failure"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)

/* dv/router_regs_vectors.txt */
# Ops: W addr data | F addr data (write, error expected) | R addr expect | E addr (read error)
# X side port idx value | P side port event count | S side port | C side value | O side expect
R 00 00400404
R 01 000005dc
R 02 0000000f
R 03 0000000f
O ing f
O egr f
W 02 00000005
R 02 00000005
O ing 5
C ing a
R 04 0000000a
X ing 2 0 00000011
X ing 2 1 00000fa0
X ing 2 2 00000002
P ing 2 0 3
P ing 2 1 1
S ing 2
W 07 00000200
R 08 00000011
W 07 00000201
R 08 00000fa0
W 07 00000202
R 08 00000002
W 07 00000203
R 08 00000003
W 07 00000204
R 08 00000001
S ing 2
R 08 00000000
W 07 00000203
R 08 00000000
X egr 1 0 00000022
X egr 1 1 00000800
X egr 1 2 00000004
P egr 1 0 2
S egr 1
W 0a 00000100
R 0b 00000022
W 0a 00000103
R 0b 00000002
E 0c
E 20
F 14 00000001
W 00 12345678
R 00 00400404
R 02 00000005
W 07 00000205
R 08 00000000
